//--- design/alu_unit.sv
// Single-cycle integer ALU with a one-entry registered result slot
`default_nettype none
`timescale 1ns/1ps

module alu_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    output logic                     issue_ready,
    input  core_config_pkg::id_t     issue_id,
    input  logic [4:0]               issue_rd,
    input  logic [31:0]              op_a,
    input  logic [31:0]              op_b,
    input  core_config_pkg::alu_op_t alu_op,
    output logic                     result_valid,
    input  logic                     result_ready,
    output core_config_pkg::id_t     result_id,
    output logic [4:0]               result_rd,
    output logic [31:0]              result_value
);
    import core_config_pkg::*;

    logic [31:0] alu_result;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SLT:  alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'd0, op_a < op_b};
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
            default:  alu_result = op_b;
        endcase
    end

    // Slot refills when empty or drained this cycle
    assign issue_ready = !result_valid || result_ready;

    always_ff @(posedge clk) begin
        if (rst)
            result_valid <= 1'b0;
        else if (issue_ready)
            result_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            result_id <= issue_id;
            result_rd <= issue_rd;
            result_value <= (issue_rd == 5'd0) ? 32'd0 : alu_result;
        end
    end

endmodule

`default_nettype wire

//--- design/core_config_pkg.sv
// Core configuration: instruction ID type, ALU and MUL operation codes, parameter defaults
`default_nettype none

package core_config_pkg;

    // Top level parameter defaults
    localparam int DEFAULT_NUM_IDS = 8;
    localparam int DEFAULT_MUL_STAGES = 3;

    // Instruction ID, wide enough for DEFAULT_NUM_IDS
    typedef logic [2:0] id_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // Multiply variants, high word for all but MUL_LO
    typedef enum logic [1:0] {
        MUL_LO,
        MUL_H,
        MUL_HSU,
        MUL_HU
    } mul_op_t;

endpackage

`default_nettype wire

//--- design/decode_and_issue.sv
// Instruction decode, operand hazard check, operand select and issue to the ALU or MUL unit
`default_nettype none
`timescale 1ns/1ps

module decode_and_issue (
    input  logic                     instr_valid,
    output logic                     instr_ready,
    input  logic [31:0]              instr_data,
    input  logic [31:0]              instr_pc,
    input  logic                     id_available,
    input  core_config_pkg::id_t     next_id,
    output logic                     id_assign,
    output logic [31:0]              issue_pc,
    output logic [4:0]               rs1_addr,
    output logic [4:0]               rs2_addr,
    input  logic [31:0]              rs1_data,
    input  logic [31:0]              rs2_data,
    input  logic                     rs1_pending,
    input  logic                     rs2_pending,
    input  logic                     rd_pending,
    output logic                     set_pending,
    output logic [4:0]               set_rd,
    input  logic                     alu_issue_ready,
    input  logic                     mul_issue_ready,
    output logic                     alu_issue_valid,
    output logic                     mul_issue_valid,
    output core_config_pkg::id_t     issue_id,
    output logic [4:0]               issue_rd,
    output logic [31:0]              op_a,
    output logic [31:0]              op_b,
    output core_config_pkg::alu_op_t alu_op,
    output core_config_pkg::mul_op_t mul_op
);
    import core_config_pkg::*;
    import riscv_types_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic is_op;
    logic is_op_imm;
    logic is_lui;
    logic is_mul;
    logic alu_legal;
    logic hazard;
    logic unit_ready;
    logic issue;

    assign opcode = instr_data[6:0];
    assign funct3 = instr_data[14:12];
    assign funct7 = instr_data[31:25];

    assign is_lui = opcode == OPC_LUI;
    assign is_mul = opcode == OPC_OP && funct7 == F7_MULDIV && !funct3[2];

    // Integer forms, only shifts and ADD/SUB take the alternate funct7
    always_comb begin
        is_op = 1'b0;
        is_op_imm = 1'b0;
        if (opcode == OPC_OP)
            is_op = funct7 == F7_BASE
                || (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
        if (opcode == OPC_OP_IMM) begin
            case (funct3)
                F3_SLL:  is_op_imm = funct7 == F7_BASE;
                F3_SR:   is_op_imm = funct7 == F7_BASE || funct7 == F7_ALT;
                default: is_op_imm = 1'b1;
            endcase
        end
    end

    assign alu_legal = is_op || is_op_imm || is_lui;

    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu_op = (is_op && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SR:      alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            default:    alu_op = ALU_AND;
        endcase
        if (is_lui || !alu_legal)
            alu_op = ALU_LUI;
    end

    always_comb begin
        case (funct3)
            F3_MULH:   mul_op = MUL_H;
            F3_MULHSU: mul_op = MUL_HSU;
            F3_MULHU:  mul_op = MUL_HU;
            default:   mul_op = MUL_LO;
        endcase
    end

    assign rs1_addr = get_rs1(instr_data);
    assign rs2_addr = get_rs2(instr_data);

    // Unsupported words become a no-op on the ALU writing x0
    assign set_rd = (alu_legal || is_mul) ? get_rd(instr_data) : 5'd0;

    assign op_a = rs1_data;
    assign op_b = (is_op || is_mul) ? rs2_data : is_lui ? get_imm_u(instr_data) : get_imm_i(instr_data);

    ///////////////////////////////////////////////////////////////////////
    // Issue control
    assign hazard = ((is_op || is_op_imm || is_mul) && rs1_pending)
        || ((is_op || is_mul) && rs2_pending) || rd_pending;
    assign unit_ready = is_mul ? mul_issue_ready : alu_issue_ready;
    assign instr_ready = id_available && unit_ready && !hazard;
    assign issue = instr_valid && instr_ready;

    assign id_assign = issue;
    assign issue_pc = instr_pc;
    assign issue_id = next_id;
    assign issue_rd = set_rd;
    assign set_pending = issue && set_rd != 5'd0;
    assign alu_issue_valid = issue && !is_mul;
    assign mul_issue_valid = issue && is_mul;

endmodule

`default_nettype wire

//--- design/id_management.sv
// Instruction ID free pool with lowest-free selection and a pc table indexed by ID
`default_nettype none
`timescale 1ns/1ps

module id_management #(
    parameter int NUM_IDS = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 id_assign,
    input  logic [31:0]          issue_pc,
    input  logic                 id_free,
    input  core_config_pkg::id_t free_id,
    output logic                 id_available,
    output core_config_pkg::id_t next_id,
    output logic [31:0]          free_pc
);
    import core_config_pkg::*;

    logic [NUM_IDS-1:0] busy;
    logic [31:0] pc_table [NUM_IDS];

    // Lowest free ID wins, so scan from the top down
    always_comb begin
        id_available = 1'b0;
        next_id = '0;
        for (int i = NUM_IDS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                id_available = 1'b1;
                next_id = id_t'(i);
            end
        end
    end

    // Assigned ID is free and freed ID is busy, so they never collide
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (id_free)
                busy[free_id] <= 1'b0;
            if (id_assign)
                busy[next_id] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (id_assign)
            pc_table[next_id] <= issue_pc;
    end

    assign free_pc = pc_table[free_id];

endmodule

`default_nettype wire

//--- design/mul_unit.sv
// Pipelined 32x32 multiplier returning the low or high product word
`default_nettype none
`timescale 1ns/1ps

module mul_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    output logic                     issue_ready,
    input  core_config_pkg::id_t     issue_id,
    input  logic [4:0]               issue_rd,
    input  logic [31:0]              op_a,
    input  logic [31:0]              op_b,
    input  core_config_pkg::mul_op_t mul_op,
    output logic                     result_valid,
    input  logic                     result_ready,
    output core_config_pkg::id_t     result_id,
    output logic [4:0]               result_rd,
    output logic [31:0]              result_value
);
    import core_config_pkg::*;

    localparam int LAST = MUL_STAGES - 1;

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] product;
    logic advance;

    logic [MUL_STAGES-1:0] valid_q;
    id_t         id_q [MUL_STAGES];
    logic [4:0]  rd_q [MUL_STAGES];
    logic        high_q [MUL_STAGES];
    logic [63:0] prod_q [MUL_STAGES];

    // Sign extension per variant, low word is the same either way
    assign a_ext = {(mul_op != MUL_HU) && op_a[31], op_a};
    assign b_ext = {(mul_op == MUL_LO || mul_op == MUL_H) && op_b[31], op_b};
    assign product = a_ext * b_ext;

    // Whole pipe moves together
    assign advance = !valid_q[LAST] || result_ready;
    assign issue_ready = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q[0] <= issue_valid;
            for (int s = 1; s < MUL_STAGES; s++)
                valid_q[s] <= valid_q[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_q[0] <= issue_id;
            rd_q[0] <= issue_rd;
            high_q[0] <= mul_op != MUL_LO;
            prod_q[0] <= product[63:0];
            for (int s = 1; s < MUL_STAGES; s++) begin
                id_q[s] <= id_q[s-1];
                rd_q[s] <= rd_q[s-1];
                high_q[s] <= high_q[s-1];
                prod_q[s] <= prod_q[s-1];
            end
        end
    end

    assign result_valid = valid_q[LAST];
    assign result_id = id_q[LAST];
    assign result_rd = rd_q[LAST];
    assign result_value = (rd_q[LAST] == 5'd0) ? 32'd0
        : high_q[LAST] ? prod_q[LAST][63:32] : prod_q[LAST][31:0];

endmodule

`default_nettype wire

//--- design/register_file.sv
// 32-entry integer register file with a per-register pending scoreboard
`default_nettype none
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic        set_pending,
    input  logic [4:0]  set_rd,
    input  logic        wb_we,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_value,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic        rs1_pending,
    output logic        rs2_pending,
    output logic        rd_pending
);
    logic [31:0] regs [32];
    logic [31:0] pending;

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != 5'd0)
            regs[wb_rd] <= wb_value;
    end

    // Set and clear cannot hit the same register, issue stalls on a pending rd
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb_we)
                pending[wb_rd] <= 1'b0;
            if (set_pending && set_rd != 5'd0)
                pending[set_rd] <= 1'b1;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

    assign rs1_pending = pending[rs1_addr];
    assign rs2_pending = pending[rs2_addr];
    assign rd_pending = pending[set_rd];

endmodule

`default_nettype wire

//--- design/riscv_types_pkg.sv
// RV32 opcode, funct3 and funct7 constants and instruction field extraction functions
`default_nettype none

package riscv_types_pkg;

    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    // Integer funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // M extension funct3
    localparam logic [2:0] F3_MUL = 3'b000;
    localparam logic [2:0] F3_MULH = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU = 3'b011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    function automatic logic [4:0] get_rs1(input logic [31:0] instr);
        return instr[19:15];
    endfunction

    function automatic logic [4:0] get_rs2(input logic [31:0] instr);
        return instr[24:20];
    endfunction

    function automatic logic [4:0] get_rd(input logic [31:0] instr);
        return instr[11:7];
    endfunction

    function automatic logic [31:0] get_imm_i(input logic [31:0] instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [31:0] get_imm_u(input logic [31:0] instr);
        return {instr[31:12], 12'b0};
    endfunction

endpackage

`default_nettype wire

//--- design/rv_core.sv
// Core top level: ID management, decode and issue, register file, ALU, MUL and writeback
`default_nettype none
`timescale 1ns/1ps

module rv_core #(
    parameter int NUM_IDS = core_config_pkg::DEFAULT_NUM_IDS,
    parameter int MUL_STAGES = core_config_pkg::DEFAULT_MUL_STAGES
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    output logic        instr_ready,
    input  logic [31:0] instr_data,
    input  logic [31:0] instr_pc,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_value
);
    import core_config_pkg::*;

    // ID pool
    logic id_available, id_assign, id_free;
    id_t next_id, free_id;
    logic [31:0] issue_pc, free_pc;

    // Register file and scoreboard
    logic [4:0] rs1_addr, rs2_addr, set_rd, wb_rd;
    logic [31:0] rs1_data, rs2_data, wb_value;
    logic rs1_pending, rs2_pending, rd_pending, set_pending, wb_we;

    // Issue payload
    logic alu_issue_valid, alu_issue_ready, mul_issue_valid, mul_issue_ready;
    id_t issue_id;
    logic [4:0] issue_rd;
    logic [31:0] op_a, op_b;
    alu_op_t alu_op;
    mul_op_t mul_op;

    // Unit results
    logic alu_valid, alu_ready, mul_valid, mul_ready;
    id_t alu_id, mul_id;
    logic [4:0] alu_rd, mul_rd;
    logic [31:0] alu_value, mul_value;

    ///////////////////////////////////////////////////////////////////////
    // Front end
    id_management #(.NUM_IDS(NUM_IDS)) id_management_block (
        .clk, .rst, .id_assign, .issue_pc, .id_free, .free_id,
        .id_available, .next_id, .free_pc
    );

    decode_and_issue decode_and_issue_block (
        .instr_valid, .instr_ready, .instr_data, .instr_pc, .id_available, .next_id,
        .id_assign, .issue_pc, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rs1_pending, .rs2_pending, .rd_pending, .set_pending, .set_rd,
        .alu_issue_ready, .mul_issue_ready, .alu_issue_valid, .mul_issue_valid,
        .issue_id, .issue_rd, .op_a, .op_b, .alu_op, .mul_op
    );

    register_file register_file_block (
        .clk, .rst, .rs1_addr, .rs2_addr, .set_pending, .set_rd, .wb_we, .wb_rd,
        .wb_value, .rs1_data, .rs2_data, .rs1_pending, .rs2_pending, .rd_pending
    );

    ///////////////////////////////////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_block (
        .clk, .rst, .issue_valid(alu_issue_valid), .issue_ready(alu_issue_ready),
        .issue_id, .issue_rd, .op_a, .op_b, .alu_op,
        .result_valid(alu_valid), .result_ready(alu_ready), .result_id(alu_id),
        .result_rd(alu_rd), .result_value(alu_value)
    );

    mul_unit #(.MUL_STAGES(MUL_STAGES)) mul_unit_block (
        .clk, .rst, .issue_valid(mul_issue_valid), .issue_ready(mul_issue_ready),
        .issue_id, .issue_rd, .op_a, .op_b, .mul_op,
        .result_valid(mul_valid), .result_ready(mul_ready), .result_id(mul_id),
        .result_rd(mul_rd), .result_value(mul_value)
    );

    ///////////////////////////////////////////////////////////////////////
    // Writeback and retire
    write_back write_back_block (
        .alu_valid, .alu_ready, .alu_id, .alu_rd, .alu_value,
        .mul_valid, .mul_ready, .mul_id, .mul_rd, .mul_value, .free_pc,
        .wb_we, .wb_rd, .wb_value, .id_free, .free_id,
        .retire_valid, .retire_pc, .retire_rd, .retire_value
    );

endmodule

`default_nettype wire

//--- design/write_back.sv
// Writeback select between MUL and ALU results, register write, ID free and retire record
`default_nettype none
`timescale 1ns/1ps

module write_back (
    input  logic                 alu_valid,
    output logic                 alu_ready,
    input  core_config_pkg::id_t alu_id,
    input  logic [4:0]           alu_rd,
    input  logic [31:0]          alu_value,
    input  logic                 mul_valid,
    output logic                 mul_ready,
    input  core_config_pkg::id_t mul_id,
    input  logic [4:0]           mul_rd,
    input  logic [31:0]          mul_value,
    input  logic [31:0]          free_pc,
    output logic                 wb_we,
    output logic [4:0]           wb_rd,
    output logic [31:0]          wb_value,
    output logic                 id_free,
    output core_config_pkg::id_t free_id,
    output logic                 retire_valid,
    output logic [31:0]          retire_pc,
    output logic [4:0]           retire_rd,
    output logic [31:0]          retire_value
);

    // MUL always wins, the ALU waits in its slot
    assign mul_ready = 1'b1;
    assign alu_ready = !mul_valid;

    assign retire_valid = mul_valid || alu_valid;
    assign free_id = mul_valid ? mul_id : alu_id;
    assign retire_rd = mul_valid ? mul_rd : alu_rd;
    assign retire_value = mul_valid ? mul_value : alu_value;
    assign retire_pc = free_pc;

    assign id_free = retire_valid;
    assign wb_we = retire_valid && retire_rd != 5'd0;
    assign wb_rd = retire_rd;
    assign wb_value = retire_value;

endmodule

`default_nettype wire

//--- list.f
design/core_config_pkg.sv
design/riscv_types_pkg.sv
design/id_management.sv
design/decode_and_issue.sv
design/register_file.sv
design/alu_unit.sv
design/mul_unit.sv
design/write_back.sv
design/rv_core.sv
testbench/rv_core_assert.sv
testbench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv_core_tb -f list.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/rv_core_assert.sv
// Concurrent assertions on the rv_core reset, retire and instruction stream ports
`default_nettype none
`timescale 1ns/1ps

module rv_core_assert (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  logic        instr_ready,
    input  logic [31:0] instr_data,
    input  logic [31:0] instr_pc,
    input  logic        retire_valid,
    input  logic [4:0]  retire_rd,
    input  logic [31:0] retire_value
);

    // Nothing retires straight out of reset
    reset_quiet: assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire_valid high in the cycle after reset");

    // x0 results are always zero
    x0_value_zero: assert property (@(posedge clk) disable iff (rst)
        retire_valid && retire_rd == 5'd0 |-> retire_value == 32'd0)
        else $error("nonzero retire_value %h for rd 0", retire_value);

    // Stream data holds while the core stalls
    stream_stable: assert property (@(posedge clk) disable iff (rst)
        instr_valid && !instr_ready |=> $stable(instr_data) && $stable(instr_pc))
        else $error("instr_data or instr_pc changed while waiting for instr_ready");

endmodule

`default_nettype wire

//--- testbench/rv_core_tb.sv
// Clock, reset, directed and random stimulus, reference model and retire compare for rv_core
`default_nettype none
`timescale 1ns/1ps

module rv_core_tb;

    logic clk = 1'b0;
    logic rst;
    logic instr_valid;
    logic instr_ready;
    logic [31:0] instr_data;
    logic [31:0] instr_pc;
    logic retire_valid;
    logic [31:0] retire_pc;
    logic [4:0] retire_rd;
    logic [31:0] retire_value;

    logic [31:0] shadow [32];
    logic [4:0]  exp_rd [logic [31:0]];
    logic [31:0] exp_value [logic [31:0]];
    bit          retired [logic [31:0]];
    logic [31:0] lcg_state = 32'h49d6;
    logic [31:0] pc_next = 32'h1000;
    logic hung = 1'b0;
    int sent_count = 0;
    int retire_count = 0;
    int mismatch_count = 0;
    int other_count = 0;

    // MUL pipe as deep as the ID pool so a MUL burst can hold every ID
    rv_core #(.NUM_IDS(8), .MUL_STAGES(8)) u_rv_core (
        .clk, .rst, .instr_valid, .instr_ready, .instr_data, .instr_pc,
        .retire_valid, .retire_pc, .retire_rd, .retire_value
    );

    bind rv_core rv_core_assert u_rv_core_assert (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr_data(instr_data), .instr_pc(instr_pc), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_value(retire_value)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // Encoders and random source
    function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_op(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Registers limited to x0..x15 so hazards are frequent
    function automatic logic [31:0] random_word(input logic mul_only);
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0] f3;
        logic [2:0] kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        r = next_rand();
        s = next_rand();
        rd = {1'b0, r[31:28]};
        rs1 = {1'b0, r[27:24]};
        rs2 = {1'b0, r[23:20]};
        f3 = r[19:17];
        kind = mul_only ? 3'd5 : s[31:29];
        case (kind)
            3'd0, 3'd1: return r_op((s[28] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                    f3, rd, rs1, rs2);
            3'd2, 3'd3: return i_op(f3, rd, rs1, (f3 == 3'd1 || f3 == 3'd5)
                ? {(f3 == 3'd5 && s[28]) ? 7'h20 : 7'h00, s[20:16]} : s[27:16]);
            3'd4: return lui(rd, s[27:8]);
            3'd5, 3'd6: return r_op(7'h01, {1'b0, f3[1:0]}, rd, rs1, rs2);
            default: return {s[27:3], 7'h0b};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Reference model run in program order against the shadow registers
    function automatic logic [31:0] reference(input logic [31:0] w, output logic [4:0] rd);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] p;
        logic [31:0] res;
        logic [2:0] f3;
        logic [6:0] f7;
        logic legal;
        a = shadow[w[19:15]];
        b = (w[6:0] == 7'h13) ? {{20{w[31]}}, w[31:20]} : shadow[w[24:20]];
        f3 = w[14:12];
        f7 = w[31:25];
        rd = w[11:7];
        legal = 1'b1;
        res = 32'd0;
        if (w[6:0] == 7'h37) begin
            res = {w[31:12], 12'd0};
        end else if (w[6:0] == 7'h33 && f7 == 7'h01 && !f3[2]) begin
            case (f3[1:0])
                2'd1: p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                2'd2: p = {{32{a[31]}}, a} * {32'd0, b};
                default: p = {32'd0, a} * {32'd0, b};
            endcase
            res = (f3[1:0] == 2'd0) ? p[31:0] : p[63:32];
        end else if (w[6:0] == 7'h33 || w[6:0] == 7'h13) begin
            if (w[5])
                legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            else if (f3 == 3'd1)
                legal = f7 == 7'h00;
            else if (f3 == 3'd5)
                legal = f7 == 7'h00 || f7 == 7'h20;
            case (f3)
                3'd0: res = (w[5] && f7[5]) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = {31'd0, $signed(a) < $signed(b)};
                3'd3: res = {31'd0, a < b};
                3'd4: res = a ^ b;
                3'd5: begin
                    if (f7[5])
                        res = $signed(a) >>> b[4:0];
                    else
                        res = a >> b[4:0];
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else begin
            legal = 1'b0;
        end
        if (!legal)
            rd = 5'd0;
        if (rd == 5'd0)
            res = 32'd0;
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Stimulus tasks start and end on a falling edge
    task automatic send(input logic [31:0] word);
        int waited;
        logic taken;
        logic [4:0] rd;
        logic [31:0] value;
        if (!hung) begin
            value = reference(word, rd);
            if (rd != 5'd0)
                shadow[rd] = value;
            exp_rd[pc_next] = rd;
            exp_value[pc_next] = value;
            sent_count++;
            instr_valid = 1'b1;
            instr_data = word;
            instr_pc = pc_next;
            pc_next += 32'd4;
            taken = 1'b0;
            waited = 0;
            // Ready settles mid cycle and holds until the rising edge
            while (!taken && waited < 100) begin
                #5;
                taken = instr_ready;
                @(negedge clk);
                waited++;
            end
            instr_valid = 1'b0;
            assert (taken) else begin
                hung = 1'b1;
                other_count++;
                $display("%0t: instruction at pc %h not accepted within 100 cycles",
                         $time, instr_pc);
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Retire compare
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            retire_count++;
            assert (exp_rd.exists(retire_pc)) else begin
                other_count++;
                $display("%0t: retire of pc %h that was never issued", $time, retire_pc);
            end
            assert (!retired.exists(retire_pc)) else begin
                other_count++;
                $display("%0t: pc %h retired a second time", $time, retire_pc);
            end
            if (exp_rd.exists(retire_pc)) begin
                assert (retire_rd == exp_rd[retire_pc]) else begin
                    mismatch_count++;
                    $display("mismatch at %0t: retire_rd for pc %h is %0d, expected %0d",
                             $time, retire_pc, retire_rd, exp_rd[retire_pc]);
                end
                assert (retire_value == exp_value[retire_pc]) else begin
                    mismatch_count++;
                    $display("mismatch at %0t: retire_value for pc %h is %h, expected %h",
                             $time, retire_pc, retire_value, exp_value[retire_pc]);
                end
            end
            retired[retire_pc] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        logic [31:0] r;
        int waited;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr_data = 32'd0;
        instr_pc = 32'd0;
        foreach (shadow[i])
            shadow[i] = 32'd0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Known values in every register
        for (int i = 1; i < 32; i++) begin
            r = next_rand();
            send(lui(5'(i), r[31:12]));
            send(i_op(3'd0, 5'(i), 5'(i), r[11:0]));
        end

        // Independent register and immediate forms
        for (int f = 0; f < 8; f++)
            send(r_op(7'h00, 3'(f), 5'(4 + f), 5'd1, 5'd2));
        send(r_op(7'h20, 3'd0, 5'd12, 5'd1, 5'd2));
        send(r_op(7'h20, 3'd5, 5'd13, 5'd1, 5'd2));
        send(i_op(3'd1, 5'd14, 5'd1, 12'd31));
        send(i_op(3'd5, 5'd15, 5'd1, 12'd31));
        send(i_op(3'd5, 5'd16, 5'd1, 12'h41f));
        for (int f = 0; f < 8; f++)
            if (f != 1 && f != 5)
                send(i_op(3'(f), 5'(17 + f), 5'd2, 12'h8a5));
        send(lui(5'd25, 20'hfffff));

        // RAW and WAW chains where the younger ADDI overtakes the MUL
        send(r_op(7'h01, 3'd0, 5'd5, 5'd1, 5'd2));
        send(i_op(3'd0, 5'd7, 5'd3, 12'd1));
        send(r_op(7'h00, 3'd0, 5'd6, 5'd5, 5'd7));
        send(r_op(7'h01, 3'd3, 5'd6, 5'd6, 5'd6));
        send(r_op(7'h00, 3'd4, 5'd8, 5'd6, 5'd5));
        send(i_op(3'd0, 5'd5, 5'd5, 12'hfff));

        // Multiply variants on 0x80000000, 0xffffffff and 0x7fffffff
        send(lui(5'd10, 20'h80000));
        send(i_op(3'd0, 5'd11, 5'd0, 12'hfff));
        send(i_op(3'd0, 5'd12, 5'd10, 12'hfff));
        for (int f = 0; f < 4; f++)
            for (int s = 0; s < 3; s++)
                for (int t = 0; t < 3; t++)
                    send(r_op(7'h01, 3'(f), 5'(20 + s), 5'(10 + s), 5'(10 + t)));

        // x0 targets, a load, a DIV and an all-ones word
        send(i_op(3'd0, 5'd0, 5'd1, 12'd5));
        send(r_op(7'h01, 3'd1, 5'd0, 5'd10, 5'd11));
        send(32'h0000_2083);
        send(r_op(7'h01, 3'd4, 5'd9, 5'd1, 5'd2));
        send(32'hffff_ffff);
        send(r_op(7'h00, 3'd0, 5'd9, 5'd0, 5'd0));
        send(r_op(7'h00, 3'd6, 5'd9, 5'd0, 5'd1));

        // Eight independent MULs back to back exhaust the ID pool
        for (int i = 0; i < 8; i++)
            send(r_op(7'h01, 3'(i % 4), 5'(24 + i), 5'(1 + i), 5'(10 + i % 3)));

        // Random stream with gaps and runs of eight MULs
        for (int n = 0; n < 300; n++) begin
            send(random_word((n / 8) % 5 == 4));
            r = next_rand();
            if (r[31:30] == 2'd0)
                idle(1 + int'(r[29:28]));
        end

        waited = 0;
        while (retire_count < sent_count && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        idle(4);
        assert (retire_count == sent_count) else begin
            other_count++;
            $display("%0d of %0d instructions retired before the timeout",
                     retire_count, sent_count);
        end
        foreach (exp_rd[pc])
            assert (retired.exists(pc)) else begin
                other_count++;
                $display("pc %h never retired", pc);
            end

        $display("Summary: %0d sent, %0d retired, %0d mismatches, %0d other errors",
                 sent_count, retire_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
